/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module tb_srt_div -f compile.f
	./obj_dir/Vtb_srt_div | tee /dev/stderr | grep -x '\*\*\* PASSED \*\*\*' > /dev/null

clean:
	rm -rf obj_dir

/* compile.f */
source/srt_pkg.sv
source/srt_qds.sv
source/srt_prenorm.sv
source/srt_stage.sv
source/srt_postcorrect.sv
source/srt_apb_regs.sv
source/srt_div_top.sv
testbench/tb_clkgen.sv
testbench/tb_srt_div.sv

/* source/srt_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module srt_apb_regs import srt_pkg::*; #(
	parameter int DATA_WIDTH = 16,
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic launch,
	output logic [DATA_WIDTH-1:0] dividend,
	output logic [DATA_WIDTH-1:0] divisor,
	input logic res_valid,
	input logic [DATA_WIDTH-1:0] quotient,
	input logic [DATA_WIDTH-1:0] remainder,
	input logic res_dbz
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int ENT_W = 2 * DATA_WIDTH + 1;

	logic access;
	logic wr_div;
	logic rd_res;
	logic credits_full;			// no room for another result
	logic pop;
	logic empty;
	logic [CNT_W-1:0] in_flight;
	logic [CNT_W-1:0] count;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [ENT_W-1:0] mem [FIFO_DEPTH];	// {dbz, rem, quot}
	logic [ENT_W-1:0] head;

	assign access = psel & penable;
	assign wr_div = access & pwrite & (paddr == ADDR_DIVISOR);
	assign rd_res = access & ~pwrite & (paddr == ADDR_RESULT);
	assign empty = (count == '0);
	assign credits_full = (int'(in_flight) + int'(count)) >= FIFO_DEPTH;
	assign launch = wr_div & ~credits_full;
	assign divisor = pwdata[DATA_WIDTH-1:0];
	assign pop = rd_res & ~empty;
	assign head = mem[rd_ptr];
	assign pready = 1'b1;			// zero wait states
	assign pslverr = (wr_div & credits_full) | (rd_res & empty);

	always_ff @(posedge clk) begin
		if (access && pwrite && paddr == ADDR_DIVIDEND)
			dividend <= pwdata[DATA_WIDTH-1:0];
		if (res_valid)
			mem[wr_ptr] <= {res_dbz, remainder, quotient};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_flight <= '0;
			count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			in_flight <= in_flight + CNT_W'(launch) - CNT_W'(res_valid);
			count <= count + CNT_W'(res_valid) - CNT_W'(pop);
			if (res_valid)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			ADDR_DIVIDEND: prdata = APB_DATA_W'(dividend);
			ADDR_STATUS: prdata = {24'b0, 4'(count), 2'b0, head[ENT_W-1] & ~empty, ~empty};
			ADDR_RESULT: begin
				if (!empty)
					prdata = {16'(head[ENT_W-2:DATA_WIDTH]), 16'(head[DATA_WIDTH-1:0])};
			end
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/srt_div_top.sv */
`timescale 1ns/10ps
`default_nettype none

module srt_div_top import srt_pkg::*; #(
	parameter int DATA_WIDTH = 16,
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	localparam int NUM_STAGES = DATA_WIDTH / 2 + 1;	// one extra for the guard bits
	localparam int R_W = DATA_WIDTH + 4;
	localparam int Q_W = DATA_WIDTH + 2;
	localparam int SH_W = $clog2(DATA_WIDTH);

	logic launch;
	logic [DATA_WIDTH-1:0] dividend;
	logic [DATA_WIDTH-1:0] divisor;
	logic res_valid;
	logic [DATA_WIDTH-1:0] quotient;
	logic [DATA_WIDTH-1:0] remainder;
	logic res_dbz;

	// pipeline chain, index 0 is the prenorm output
	logic v_c [NUM_STAGES+1];
	logic [R_W-1:0] rem_c [NUM_STAGES+1];
	logic [DATA_WIDTH-1:0] div_c [NUM_STAGES+1];
	logic [Q_W-1:0] q_c [NUM_STAGES+1];
	logic [Q_W-1:0] qm_c [NUM_STAGES+1];
	logic [SH_W-1:0] sh_c [NUM_STAGES+1];
	logic dbz_c [NUM_STAGES+1];
	logic [DATA_WIDTH-1:0] dvd_c [NUM_STAGES+1];

	assign q_c[0] = '0;
	assign qm_c[0] = '1;	// q - 1 for q = 0

	srt_apb_regs #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_apb_regs (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.launch(launch), .dividend(dividend), .divisor(divisor),
		.res_valid(res_valid), .quotient(quotient), .remainder(remainder),
		.res_dbz(res_dbz)
	);

	srt_prenorm #(.DATA_WIDTH(DATA_WIDTH)) u_prenorm (
		.clk(clk), .arst_n(arst_n),
		.launch(launch), .dividend(dividend), .divisor(divisor),
		.valid(v_c[0]), .rem(rem_c[0]), .div_norm(div_c[0]),
		.shift(sh_c[0]), .dbz(dbz_c[0]), .dividend_q(dvd_c[0])
	);

	for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
		srt_stage #(.DATA_WIDTH(DATA_WIDTH), .STAGE(g)) u_stage (
			.clk(clk), .arst_n(arst_n),
			.in_valid(v_c[g]), .in_rem(rem_c[g]), .in_div(div_c[g]),
			.in_q(q_c[g]), .in_qm(qm_c[g]), .in_shift(sh_c[g]),
			.in_dbz(dbz_c[g]), .in_dividend(dvd_c[g]),
			.out_valid(v_c[g+1]), .out_rem(rem_c[g+1]), .out_div(div_c[g+1]),
			.out_q(q_c[g+1]), .out_qm(qm_c[g+1]), .out_shift(sh_c[g+1]),
			.out_dbz(dbz_c[g+1]), .out_dividend(dvd_c[g+1])
		);
	end

	srt_postcorrect #(.DATA_WIDTH(DATA_WIDTH)) u_postcorrect (
		.clk(clk), .arst_n(arst_n),
		.in_valid(v_c[NUM_STAGES]), .in_rem(rem_c[NUM_STAGES]),
		.in_div(div_c[NUM_STAGES]), .in_q(q_c[NUM_STAGES]), .in_qm(qm_c[NUM_STAGES]),
		.in_shift(sh_c[NUM_STAGES]), .in_dbz(dbz_c[NUM_STAGES]),
		.in_dividend(dvd_c[NUM_STAGES]),
		.res_valid(res_valid), .quotient(quotient), .remainder(remainder),
		.res_dbz(res_dbz)
	);

endmodule

`default_nettype wire

/* source/srt_pkg.sv */
`default_nettype none

package srt_pkg;

	parameter int APB_DATA_W = 32;	// apb bus width
	parameter int EST_W = 5;	// qds estimate index width

	// radix-4 digit with the sign in the top bit
	typedef enum logic [2:0] {
		QD_ZERO = 3'b000,
		QD_POS1 = 3'b001,
		QD_POS2 = 3'b010,
		QD_NEG2 = 3'b110,
		QD_NEG1 = 3'b111
	} qdigit_e;

	// apb word offsets
	typedef enum logic [7:0] {
		ADDR_DIVIDEND = 8'h00,
		ADDR_DIVISOR = 8'h04,	// write launches
		ADDR_STATUS = 8'h08,
		ADDR_RESULT = 8'h0C	// read pops fifo
	} reg_addr_e;

endpackage

`default_nettype wire

/* source/srt_postcorrect.sv */
`timescale 1ns/10ps
`default_nettype none

module srt_postcorrect #(
	parameter int DATA_WIDTH = 16
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [DATA_WIDTH+3:0] in_rem,
	input logic [DATA_WIDTH-1:0] in_div,
	input logic [DATA_WIDTH+1:0] in_q,
	input logic [DATA_WIDTH+1:0] in_qm,
	input logic [$clog2(DATA_WIDTH)-1:0] in_shift,
	input logic in_dbz,
	input logic [DATA_WIDTH-1:0] in_dividend,
	output logic res_valid,
	output logic [DATA_WIDTH-1:0] quotient,
	output logic [DATA_WIDTH-1:0] remainder,
	output logic res_dbz
);

	localparam int R_W = DATA_WIDTH + 4;

	logic rem_neg;
	logic [R_W-1:0] rem_fix;		// non-negative remainder, still aligned
	logic [DATA_WIDTH+1:0] q_fix;
	logic [DATA_WIDTH-1:0] rem_sh;

	assign rem_neg = in_rem[R_W-1];
	assign rem_fix = rem_neg ? (in_rem + R_W'(in_div)) : in_rem;
	assign q_fix = rem_neg ? in_qm : in_q;	// qm is q - 1
	assign rem_sh = rem_fix[DATA_WIDTH-1:0] >> in_shift;	// undo the alignment

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		res_dbz <= in_dbz;
		if (in_dbz) begin
			quotient <= '1;
			remainder <= in_dividend;
		end else begin
			quotient <= q_fix[DATA_WIDTH-1:0];
			remainder <= rem_sh;
		end
	end

endmodule

`default_nettype wire

/* source/srt_prenorm.sv */
`timescale 1ns/10ps
`default_nettype none

module srt_prenorm #(
	parameter int DATA_WIDTH = 16
) (
	input logic clk,
	input logic arst_n,
	input logic launch,
	input logic [DATA_WIDTH-1:0] dividend,
	input logic [DATA_WIDTH-1:0] divisor,
	output logic valid,
	output logic [DATA_WIDTH+3:0] rem,
	output logic [DATA_WIDTH-1:0] div_norm,
	output logic [$clog2(DATA_WIDTH)-1:0] shift,
	output logic dbz,
	output logic [DATA_WIDTH-1:0] dividend_q
);

	localparam int R_W = DATA_WIDTH + 4;
	localparam int SH_W = $clog2(DATA_WIDTH);

	logic [SH_W-1:0] lz;			// leading zeros of divisor
	logic found;
	logic [2*DATA_WIDTH-1:0] x_sh;		// aligned dividend
	logic [R_W-1:0] rem_init;

	always_comb begin
		lz = '0;
		found = 1'b0;
		for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
			if (divisor[i])
				found = 1'b1;
			else if (!found)
				lz = lz + 1'b1;
		end
	end

	assign x_sh = {{DATA_WIDTH{1'b0}}, dividend} << lz;

	// top part of the aligned dividend, two guard bits down;
	// the low DATA_WIDTH+2 bits are fed in by the stages
	assign rem_init = R_W'(x_sh >> (DATA_WIDTH + 2));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid <= 1'b0;
		else
			valid <= launch;
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			rem <= rem_init;
			div_norm <= divisor << lz;
			shift <= lz;
			dbz <= (divisor == '0);
			dividend_q <= dividend;
		end
	end

endmodule

`default_nettype wire

/* source/srt_qds.sv */
`timescale 1ns/10ps
`default_nettype none

module srt_qds import srt_pkg::*; (
	input logic [EST_W-1:0] r_idx,	// 4r estimate, two's complement, 3 frac bits
	input logic [EST_W-1:0] d_idx,	// divisor estimate, 1xxx
	output qdigit_e quotient
);

	logic r_neg;			// remainder sign
	logic [EST_W-1:0] r_mag;	// remainder magnitude
	logic [EST_W-1:0] thr_lo;	// below this the digit is 0
	logic [EST_W-1:0] thr_hi;	// at or above this the digit is 2
	logic is_zero;
	logic is_two;

	assign r_neg = r_idx[EST_W-1];
	assign r_mag = r_neg ? (~r_idx + 1'b1) : r_idx;

	// thresholds per divisor row; negative side sits one step higher
	// because the truncated estimate rounds toward minus infinity
	always_comb begin
		case (d_idx[3:0])
			4'b1000: begin
				thr_lo = r_neg ? 5'd3 : 5'd2;
				thr_hi = r_neg ? 5'd7 : 5'd6;
			end
			4'b1001: begin
				thr_lo = r_neg ? 5'd3 : 5'd2;
				thr_hi = r_neg ? 5'd8 : 5'd7;
			end
			4'b1010: begin
				thr_lo = r_neg ? 5'd4 : 5'd3;
				thr_hi = r_neg ? 5'd9 : 5'd8;
			end
			4'b1011: begin
				thr_lo = r_neg ? 5'd4 : 5'd3;
				thr_hi = 5'd9;
			end
			4'b1100: begin
				thr_lo = r_neg ? 5'd5 : 5'd4;
				thr_hi = 5'd10;
			end
			4'b1101: begin
				thr_lo = r_neg ? 5'd5 : 5'd4;
				thr_hi = r_neg ? 5'd11 : 5'd10;
			end
			4'b1110: begin
				thr_lo = r_neg ? 5'd5 : 5'd4;
				thr_hi = 5'd11;
			end
			4'b1111: begin
				thr_lo = r_neg ? 5'd5 : 5'd4;
				thr_hi = 5'd12;
			end
			default: begin	// unnormalised divisor, force zero
				thr_lo = 5'd31;
				thr_hi = 5'd31;
			end
		endcase
	end

	assign is_zero = (r_mag < thr_lo);
	assign is_two = (r_mag >= thr_hi);

	always_comb begin
		if (is_zero)
			quotient = QD_ZERO;	// never a negative zero
		else if (is_two)
			quotient = r_neg ? QD_NEG2 : QD_POS2;
		else
			quotient = r_neg ? QD_NEG1 : QD_POS1;
	end

endmodule

`default_nettype wire

/* source/srt_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module srt_stage import srt_pkg::*; #(
	parameter int DATA_WIDTH = 16,
	parameter int STAGE = 0
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [DATA_WIDTH+3:0] in_rem,
	input logic [DATA_WIDTH-1:0] in_div,
	input logic [DATA_WIDTH+1:0] in_q,
	input logic [DATA_WIDTH+1:0] in_qm,
	input logic [$clog2(DATA_WIDTH)-1:0] in_shift,
	input logic in_dbz,
	input logic [DATA_WIDTH-1:0] in_dividend,
	output logic out_valid,
	output logic [DATA_WIDTH+3:0] out_rem,
	output logic [DATA_WIDTH-1:0] out_div,
	output logic [DATA_WIDTH+1:0] out_q,
	output logic [DATA_WIDTH+1:0] out_qm,
	output logic [$clog2(DATA_WIDTH)-1:0] out_shift,
	output logic out_dbz,
	output logic [DATA_WIDTH-1:0] out_dividend
);

	localparam int R_W = DATA_WIDTH + 4;
	localparam int Q_W = DATA_WIDTH + 2;
	localparam int BIT_POS = DATA_WIDTH + 1 - 2 * STAGE;	// dividend bits fed here

	logic [2*DATA_WIDTH-1:0] x_sh;
	logic [R_W-1:0] w;			// 4r plus fed bits
	logic signed [6:0] r_top;		// wide estimate before saturation
	logic [EST_W-1:0] r_idx;
	logic [EST_W-1:0] d_idx;
	logic [R_W-1:0] d_ext;
	qdigit_e digit;
	logic [R_W-1:0] rem_next;
	logic [Q_W-1:0] q_next;
	logic [Q_W-1:0] qm_next;

	assign x_sh = {{DATA_WIDTH{1'b0}}, in_dividend} << in_shift;
	assign w = {in_rem[R_W-3:0], x_sh[BIT_POS -: 2]};
	assign r_top = $signed(w[R_W-1:DATA_WIDTH-3]);

	// clamp to +-15 so the magnitude fits four bits
	always_comb begin
		if (r_top > 7'sd15)
			r_idx = 5'sd15;
		else if (r_top < -7'sd15)
			r_idx = 5'b10001;
		else
			r_idx = r_top[EST_W-1:0];
	end

	assign d_idx = {1'b0, in_div[DATA_WIDTH-1 -: 4]};
	assign d_ext = R_W'(in_div);

	srt_qds u_qds (
		.r_idx(r_idx),
		.d_idx(d_idx),
		.quotient(digit)
	);

	// next remainder and on-the-fly quotient update
	always_comb begin
		case (digit)
			QD_POS1: begin
				rem_next = w - d_ext;
				q_next = {in_q[Q_W-3:0], 2'd1};
				qm_next = {in_q[Q_W-3:0], 2'd0};
			end
			QD_POS2: begin
				rem_next = w - (d_ext << 1);
				q_next = {in_q[Q_W-3:0], 2'd2};
				qm_next = {in_q[Q_W-3:0], 2'd1};
			end
			QD_NEG1: begin
				rem_next = w + d_ext;
				q_next = {in_qm[Q_W-3:0], 2'd3};
				qm_next = {in_qm[Q_W-3:0], 2'd2};
			end
			QD_NEG2: begin
				rem_next = w + (d_ext << 1);
				q_next = {in_qm[Q_W-3:0], 2'd2};
				qm_next = {in_qm[Q_W-3:0], 2'd1};
			end
			default: begin
				rem_next = w;
				q_next = {in_q[Q_W-3:0], 2'd0};
				qm_next = {in_qm[Q_W-3:0], 2'd3};
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		out_rem <= rem_next;
		out_div <= in_div;
		out_q <= q_next;
		out_qm <= qm_next;
		out_shift <= in_shift;
		out_dbz <= in_dbz;
		out_dividend <= in_dividend;
	end

endmodule

`default_nettype wire

/* testbench/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;	// released on a rising edge
	end

endmodule

`default_nettype wire

/* testbench/tb_srt_div.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_srt_div import srt_pkg::*; ();

	localparam int DATA_WIDTH = 16;
	localparam int FIFO_DEPTH = 4;
	localparam int RAND_SEED = 6;
	localparam int N_DIRECTED = 58;
	localparam int N_RANDOM = 300;
	localparam int N_DBZ = 3;
	localparam int N_DIVS = N_DIRECTED + N_RANDOM + N_DBZ + FIFO_DEPTH + 2;
	localparam int MAX_CYCLES = 40 * N_DIVS + 200;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;

	logic [32:0] exp_q[$];	// {dbz, rem, quot}
	logic [32:0] got_q[$];	// same layout as read back
	logic [32:0] got_ent;
	logic [32:0] exp_ent;
	int errors;
	int checks;
	int pending;		// launched but not yet popped
	int cycles;

	tb_clkgen #(.PERIOD(10), .RESET_CYCLES(2)) u_clkgen (
		.clk(clk),
		.arst_n(arst_n)
	);

	srt_div_top #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_srt_div_top (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	// integer quotient and remainder packed as {rem, quot}
	function automatic logic [31:0] ref_div(input logic [DATA_WIDTH-1:0] a,
			input logic [DATA_WIDTH-1:0] b);
		logic [DATA_WIDTH-1:0] q;
		logic [DATA_WIDTH-1:0] r;
		if (b == '0) begin
			q = '1;
			r = a;
		end else begin
			q = a / b;
			r = a % b;
		end
		return {16'(r), 16'(q)};
	endfunction

	task automatic apb_write(input reg_addr_e addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;	// sampled in the access phase
		check_val("pready", 32'(pready), 32'h1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input reg_addr_e addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		check_val("pready", 32'(pready), 32'h1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// wait for a result, then pop it with its dbz flag
	task automatic pop_result();
		logic [31:0] status;
		logic [31:0] data;
		logic err;
		status = '0;
		while (!status[0])
			apb_read(ADDR_STATUS, status, err);
		apb_read(ADDR_RESULT, data, err);
		check_val("pslverr", 32'(err), 32'h0);
		got_q.push_back({status[1], data});
	endtask

	task automatic drain_results();
		repeat (pending) pop_result();
		pending = 0;
	endtask

	task automatic run_div(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
		logic err;
		if (pending == FIFO_DEPTH)
			drain_results();
		apb_write(ADDR_DIVIDEND, APB_DATA_W'(a), err);
		apb_write(ADDR_DIVISOR, APB_DATA_W'(b), err);
		check_val("pslverr", 32'(err), 32'h0);
		exp_q.push_back({b == '0, ref_div(a, b)});
		pending++;
	endtask

	// compares every popped result against the expected queue in order
	always @(posedge clk) begin
		if (got_q.size() > 0) begin
			got_ent = got_q.pop_front();
			if (exp_q.size() == 0) begin
				errors++;
				$display("a result was read back with no division outstanding");
			end else begin
				exp_ent = exp_q.pop_front();
				check_val("quotient", 32'(got_ent[15:0]), 32'(exp_ent[15:0]));
				check_val("remainder", 32'(got_ent[31:16]), 32'(exp_ent[31:16]));
				check_val("dbz", 32'(got_ent[32]), 32'(exp_ent[32]));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not complete", cycles);
			$display("checks: %0d  errors: %0d", checks, errors);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [31:0] status;
		logic [31:0] data;
		logic err;
		int unsigned sh;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		void'($urandom(RAND_SEED));
		wait (arst_n === 1'b1);
		@(posedge clk);

		// idle state after reset
		apb_read(ADDR_STATUS, status, err);
		check_val("status", status, 32'h0);
		apb_read(ADDR_RESULT, data, err);
		check_val("prdata", data, 32'h0);
		check_val("pslverr", 32'(err), 32'h1);

		// directed corners
		run_div(DATA_WIDTH'(1), DATA_WIDTH'(1));
		run_div('1, DATA_WIDTH'(1));
		run_div('1, '1);
		run_div(DATA_WIDTH'(3), '1);
		run_div(DATA_WIDTH'(16'h8000), DATA_WIDTH'(2));
		run_div(DATA_WIDTH'(16'h4000), DATA_WIDTH'(16'h0100));
		run_div(DATA_WIDTH'(16'h0400), DATA_WIDTH'(16'h0010));
		run_div(DATA_WIDTH'(1), DATA_WIDTH'(16'h8000));
		run_div(DATA_WIDTH'(16'hfffe), '1);
		run_div(DATA_WIDTH'(16'h8000), DATA_WIDTH'(16'h8000));
		for (int row = 8; row < 16; row++) begin	// every divisor estimate row
			for (int k = 0; k < 3; k++) begin
				sh = (k == 0) ? DATA_WIDTH - 4 : (k == 1) ? DATA_WIDTH / 2 - 2 : 0;
				b = DATA_WIDTH'(row) << sh;
				run_div('1, b);
				run_div(DATA_WIDTH'(16'h5a3c), b);
			end
		end
		drain_results();

		for (int i = 0; i < N_RANDOM; i++) begin
			a = DATA_WIDTH'($urandom);
			sh = $urandom % DATA_WIDTH;	// spread divisor magnitudes
			b = DATA_WIDTH'($urandom) >> sh;
			run_div(a, b);
		end
		drain_results();

		// division by zero
		run_div(DATA_WIDTH'(16'h1234), '0);
		run_div('0, '0);
		run_div('1, '0);
		drain_results();

		// fill the result queue so that extra launches are refused
		for (int i = 0; i < FIFO_DEPTH; i++)
			run_div(DATA_WIDTH'(1000 + 17 * i), DATA_WIDTH'(7 + i));
		apb_write(ADDR_DIVIDEND, APB_DATA_W'(16'h0777), err);
		apb_write(ADDR_DIVISOR, APB_DATA_W'(3), err);
		check_val("pslverr", 32'(err), 32'h1);	// refused while in flight
		status = '0;
		while (status[7:4] != 4'(FIFO_DEPTH))
			apb_read(ADDR_STATUS, status, err);
		check_val("status", status, 32'((FIFO_DEPTH << 4) | 1));
		apb_write(ADDR_DIVISOR, APB_DATA_W'(5), err);
		check_val("pslverr", 32'(err), 32'h1);	// refused with fifo full
		drain_results();
		apb_read(ADDR_STATUS, status, err);
		check_val("status", status, 32'h0);
		apb_read(ADDR_RESULT, data, err);
		check_val("prdata", data, 32'h0);
		check_val("pslverr", 32'(err), 32'h1);

		wait (got_q.size() == 0);
		@(posedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected results were never read back", exp_q.size());
		end
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
